// ==== build.f ====
+incdir+.
pollable_pkg.sv
mem_port_if.sv
sample_delay.sv
bus_slave_engine.sv
shared_waveform_memory.sv
playback_reader.sv
pollable_memory_top.sv
pollable_memory_props.sv
pollable_memory_tb.sv

// ==== bus_slave_engine.sv ====
// ------------------------------
// host bus slave engine
// address, write and read phases with auto-increment
// ------------------------------
`timescale 1ns/1ns
`include "pollable_consts.svh"

module bus_slave_engine (
	input logic clock,
	input logic reset125,
	input logic read,
	input logic register_select,
	input logic enable,
	input pollable_pkg::half_t bus_in,
	output pollable_pkg::half_t bus_out,
	output logic bus_oe,
	output logic ack_valid,
	mem_port_if.requester mem
);
	import pollable_pkg::*;

	localparam int HALF_BITS = $clog2(`HALVES_PER_WORD);
	localparam logic [HALF_BITS-1:0] FIRST_HALF = HALF_BITS'(`HALVES_PER_WORD - 1);

	bus_ctrl_t ctrl_now;
	bus_ctrl_t ctrl_taps [`SAMPLE_DEPTH];
	half_t bus_taps [`SAMPLE_DEPTH];
	logic ack_taps [`ACK_DELAY];
	bus_ctrl_t ctrl_s, ctrl_p; // last two samples
	half_t bus_s;
	logic en_hi, en_lo, start;
	phase_t phase, kind;
	logic [HALF_BITS-1:0] half_cnt, idx;
	logic busy, fetching, ack_int;
	addr_t addr_reg;
	word_t wbuf, rbuf;

	// ------------------------------
	// input resampling and ack delay
	// ------------------------------
	assign ctrl_now = '{read: read, register_select: register_select, enable: enable};

	sample_delay #(.T(bus_ctrl_t), .DEPTH(`SAMPLE_DEPTH)) u_ctrl_delay (
		.clock(clock), .reset125(reset125), .d(ctrl_now), .taps(ctrl_taps));
	sample_delay #(.T(half_t), .DEPTH(`SAMPLE_DEPTH)) u_bus_delay (
		.clock(clock), .reset125(reset125), .d(bus_in), .taps(bus_taps));
	sample_delay #(.T(logic), .DEPTH(`ACK_DELAY)) u_ack_delay (
		.clock(clock), .reset125(reset125), .d(ack_int), .taps(ack_taps));

	assign ctrl_s = ctrl_taps[`SAMPLE_DEPTH-1];
	assign ctrl_p = ctrl_taps[`SAMPLE_DEPTH-2];
	assign bus_s = bus_taps[`SAMPLE_DEPTH-1];
	assign ack_valid = ack_taps[`ACK_DELAY-1];

	// a level only counts once two samples agree
	assign en_hi = ctrl_s.enable & ctrl_p.enable;
	assign en_lo = ~(ctrl_s.enable | ctrl_p.enable);
	assign start = en_hi & ~busy & ~mem.req
		& (ctrl_s.read == ctrl_p.read)
		& (ctrl_s.register_select == ctrl_p.register_select);

	always_comb begin
		if (ctrl_s.read) begin
			kind = PHASE_READ;
		end else if (ctrl_s.register_select) begin
			kind = PHASE_WRITE;
		end else begin
			kind = PHASE_ADDRESS;
		end
		idx = (kind == phase) ? half_cnt : FIRST_HALF; // new phase kind restarts at msb half
	end

	// ------------------------------
	// phase engine
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset125) begin
			phase <= PHASE_IDLE;
			half_cnt <= FIRST_HALF;
			busy <= 1'b0;
			fetching <= 1'b0;
			ack_int <= 1'b0;
			addr_reg <= '0;
			bus_oe <= 1'b0;
			mem.req <= 1'b0;
			mem.we <= 1'b0;
		end else begin
			if (ctrl_s.read == ctrl_p.read) begin
				bus_oe <= ctrl_s.read;
			end
			if (mem.grant) begin
				mem.req <= 1'b0;
				if (mem.we) begin
					addr_reg <= addr_reg + 1'b1; // increment once the write has landed
				end
			end
			if (start) begin
				busy <= 1'b1;
				phase <= kind;
				half_cnt <= idx;
				case (kind)
					PHASE_ADDRESS: begin
						addr_reg <= addr_t'(bus_s);
						ack_int <= 1'b1;
					end
					PHASE_WRITE: begin
						wbuf[idx*`BUS_WIDTH +: `BUS_WIDTH] <= bus_s;
						ack_int <= 1'b1;
					end
					default: begin
						if (idx == FIRST_HALF) begin // fresh word needed
							mem.req <= 1'b1;
							mem.we <= 1'b0;
							mem.addr <= addr_reg;
							fetching <= 1'b1;
						end else begin
							bus_out <= rbuf[idx*`BUS_WIDTH +: `BUS_WIDTH];
							ack_int <= 1'b1;
						end
					end
				endcase
			end
			if (fetching && mem.rvalid) begin
				rbuf <= mem.rdata;
				bus_out <= mem.rdata[FIRST_HALF*`BUS_WIDTH +: `BUS_WIDTH];
				ack_int <= 1'b1;
				fetching <= 1'b0;
			end
			// enable steady low closes the phase
			if (busy && !fetching && en_lo) begin
				busy <= 1'b0;
				ack_int <= 1'b0;
				if (phase == PHASE_WRITE && half_cnt == '0) begin
					mem.req <= 1'b1;
					mem.we <= 1'b1;
					mem.addr <= addr_reg;
					mem.wdata <= wbuf;
					half_cnt <= FIRST_HALF;
				end else if (phase == PHASE_READ && half_cnt == '0) begin
					addr_reg <= addr_reg + 1'b1;
					half_cnt <= FIRST_HALF;
				end else if (phase != PHASE_ADDRESS) begin
					half_cnt <= half_cnt - 1'b1;
				end
			end
		end
	end

endmodule

// ==== mem_port_if.sv ====
// ------------------------------
// memory request port
// ------------------------------
`timescale 1ns/1ns

interface mem_port_if;
	import pollable_pkg::*;

	logic req;
	logic we;
	addr_t addr;
	word_t wdata;
	logic grant; // one cycle, access happens here
	logic rvalid; // one cycle after a read grant
	word_t rdata;

	modport requester (
		output req, we, addr, wdata,
		input grant, rvalid, rdata
	);

	modport memory (
		input req, we, addr, wdata,
		output grant, rvalid, rdata
	);

endinterface

// ==== playback_reader.sv ====
// ------------------------------
// playback reader
// streams memory as bytes, msb first, with loop sync
// ------------------------------
`timescale 1ns/1ns
`include "pollable_consts.svh"

module playback_reader (
	input logic clock,
	input logic reset125,
	output pollable_pkg::play_byte_t play_byte,
	output logic play_sync,
	mem_port_if.requester mem
);
	import pollable_pkg::*;

	localparam int BYTE_BITS = $clog2(`BYTES_PER_WORD);
	localparam int BW = $bits(play_byte_t);
	localparam logic [BYTE_BITS-1:0] LAST_BYTE = BYTE_BITS'(`BYTES_PER_WORD - 1);

	logic [BYTE_BITS-1:0] byte_idx;
	addr_t fetch_addr;
	word_t next_word; // prefetched
	word_t cur_word; // being streamed

	assign mem.we = 1'b0; // read only port
	assign mem.wdata = '0;
	assign play_byte = cur_word[(LAST_BYTE - byte_idx)*BW +: BW];

	always_ff @(posedge clock) begin
		if (reset125) begin
			byte_idx <= '0;
			fetch_addr <= '0;
			cur_word <= '0;
			play_sync <= 1'b0;
			mem.req <= 1'b0;
		end else begin
			byte_idx <= byte_idx + 1'b1; // wraps every word
			play_sync <= 1'b0;
			if (byte_idx == '0) begin
				mem.req <= 1'b1;
				mem.addr <= fetch_addr;
				fetch_addr <= fetch_addr + 1'b1; // rolls over to word 0
			end else if (mem.grant) begin
				mem.req <= 1'b0;
			end
			if (mem.rvalid) begin
				next_word <= mem.rdata;
			end
			if (byte_idx == LAST_BYTE) begin
				cur_word <= next_word;
				play_sync <= (mem.addr == '0); // word 0 starts a new loop
			end
		end
	end

endmodule

// ==== pollable_consts.svh ====
// ------------------------------
// pollable memory constants
// bus, memory and playback sizing
// ------------------------------
`ifndef POLLABLE_CONSTS_SVH
`define POLLABLE_CONSTS_SVH

// host side
`define BUS_WIDTH 16
`define HALVES_PER_WORD 2 // bus transactions per memory word

// memory
`define ADDR_BITS 8 // 256 words

// input resampling and acknowledge
`define SAMPLE_DEPTH 3
`define ACK_DELAY 4

// playback
`define BYTES_PER_WORD 4

`endif

// ==== pollable_memory_props.sv ====
// ------------------------------
// pollable memory assertions
// reset, sync width and loop spacing
// ------------------------------
`timescale 1ns/1ns
`include "pollable_consts.svh"

module pollable_memory_props (
	input logic clock,
	input logic reset125,
	input logic ack_valid,
	input logic play_sync
);

	localparam int LOOP = (1 << `ADDR_BITS) * `BYTES_PER_WORD;

	int since_sync; // cycles since the last pulse
	logic seen_sync;

	always_ff @(posedge clock) begin
		if (reset125) begin
			since_sync <= 0;
			seen_sync <= 1'b0;
		end else if (play_sync) begin
			since_sync <= 1;
			seen_sync <= 1'b1;
		end else begin
			since_sync <= since_sync + 1;
		end
	end

	ack_low_in_reset: assert property (@(posedge clock) reset125 |=> !ack_valid)
		else $error("ack_valid high while reset125 is asserted");

	sync_one_cycle: assert property (@(posedge clock) disable iff (reset125)
		play_sync |=> !play_sync)
		else $error("play_sync high for two cycles in a row");

	sync_spacing: assert property (@(posedge clock) disable iff (reset125)
		(play_sync && seen_sync) |-> (since_sync == LOOP))
		else $error("play_sync pulses not one loop apart");

endmodule

bind pollable_memory_top pollable_memory_props u_props (.*);

// ==== pollable_memory_tb.sv ====
// ------------------------------
// pollable memory testbench
// host bus transactions, reference model and playback checker
// ------------------------------
`timescale 1ns/1ns
`include "pollable_consts.svh"

module pollable_memory_tb;
	import pollable_pkg::*;

	localparam int PERIOD = 40;
	localparam int TRANSACTIONS = 80; // host transactions below, rounded up
	localparam int LOOP = (1 << `ADDR_BITS) * `BYTES_PER_WORD;
	localparam int K_ADDR = 1;
	localparam int K_WRITE = 2;
	localparam int K_READ = 3;

	logic clock, reset125, read, register_select, enable;
	half_t bus_in, bus_out;
	logic bus_oe, ack_valid, play_sync;
	play_byte_t play_byte;

	int errors;
	int hangs; // handshakes that never completed
	// reference model state
	word_t model_mem [1 << `ADDR_BITS];
	addr_t ptr;
	int last_kind, half;
	word_t wbuf, rbuf;
	// playback checker control
	logic play_arm, play_done, play_started;
	int play_len, play_n;

	pollable_memory_top u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #(PERIOD/2) clock = ~clock;
	end

	initial begin
		#((TRANSACTIONS * 60 + 4 * LOOP + 8) * PERIOD);
		$display("timeout: the tests did not finish in time, run stopped by the watchdog");
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic half_t model_access(input int kind, input half_t data);
		half_t result;
		result = '0;
		if (kind != last_kind) begin
			half = `HALVES_PER_WORD - 1; // another phase kind starts at the msb half
		end
		last_kind = kind;
		if (kind == K_ADDR) begin
			ptr = addr_t'(data);
		end else if (kind == K_WRITE) begin
			wbuf[half*`BUS_WIDTH +: `BUS_WIDTH] = data;
			if (half == 0) begin
				model_mem[ptr] = wbuf;
				ptr = ptr + 1'b1;
				half = `HALVES_PER_WORD - 1;
			end else begin
				half = half - 1;
			end
		end else begin
			if (half == `HALVES_PER_WORD - 1) begin
				rbuf = model_mem[ptr]; // fresh word
			end
			result = rbuf[half*`BUS_WIDTH +: `BUS_WIDTH];
			if (half == 0) begin
				ptr = ptr + 1'b1;
				half = `HALVES_PER_WORD - 1;
			end else begin
				half = half - 1;
			end
		end
		return result;
	endfunction

	// byte n of the loop, msb of each word first
	function automatic play_byte_t model_play_byte(input int n);
		word_t w;
		int b;
		w = model_mem[addr_t'(n / `BYTES_PER_WORD)];
		b = `BYTES_PER_WORD - 1 - (n % `BYTES_PER_WORD);
		return w[b*$bits(play_byte_t) +: $bits(play_byte_t)];
	endfunction

	// ------------------------------
	// host bus tasks
	// ------------------------------
	task automatic bus_cycle(input logic rd, input logic rs, input half_t data,
		output half_t rdata);
		int waited;
		@(posedge clock);
		#2;
		read = rd;
		register_select = rs;
		bus_in = data;
		enable = 1'b1;
		waited = 0;
		@(negedge clock);
		while (!ack_valid && waited < 60) begin
			@(negedge clock);
			waited++;
		end
		rdata = bus_out;
		if (!ack_valid) begin
			hangs++;
			$display("ack_valid did not rise within 60 cycles, time %0t ns", $time);
		end
		if (ack_valid && bus_oe !== rd) begin
			errors++;
			$display("ERROR %0t ns: bus_oe is %b while read is %b", $time, bus_oe, rd);
		end
		@(posedge clock);
		#2;
		enable = 1'b0;
		waited = 0;
		@(negedge clock);
		while (ack_valid && waited < 60) begin
			@(negedge clock);
			waited++;
		end
		if (ack_valid) begin
			hangs++;
			$display("ack_valid did not fall within 60 cycles, time %0t ns", $time);
		end
	endtask

	task automatic set_address(input addr_t a);
		half_t got;
		bus_cycle(1'b0, 1'b0, half_t'(a), got);
		void'(model_access(K_ADDR, half_t'(a)));
	endtask

	task automatic write_half(input half_t d);
		half_t got;
		bus_cycle(1'b0, 1'b1, d, got);
		void'(model_access(K_WRITE, d));
	endtask

	task automatic read_half();
		half_t got, exp;
		exp = model_access(K_READ, '0);
		bus_cycle(1'b1, 1'b1, '0, got);
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns: read half %h, expected %h", $time, got, exp);
		end
	endtask

	// arms the checker and waits until it has seen len bytes after play_sync
	task automatic check_playback(input int len);
		int waited;
		play_len = len;
		play_arm = 1'b1;
		waited = 0;
		while (!play_done && waited < 2 * LOOP + len) begin
			@(posedge clock);
			waited++;
		end
		if (!play_done) begin
			hangs++;
			$display("no play_sync pulse was seen, playback could not be checked");
		end
		play_arm = 1'b0;
		@(posedge clock);
	endtask

	// ------------------------------
	// playback checker
	// ------------------------------
	always @(negedge clock) begin
		if (!play_arm) begin
			play_done = 1'b0;
			play_started = 1'b0;
			play_n = 0;
		end else if (!play_done) begin
			if (play_sync) begin
				play_started = 1'b1; // loop starts at word 0
				play_n = 0;
			end
			if (play_started) begin
				if (play_byte !== model_play_byte(play_n)) begin
					errors++;
					$display("ERROR %0t ns: playback byte %0d is %h, expected %h", $time,
						play_n, play_byte, model_play_byte(play_n));
				end
				play_n++;
				if (play_n == play_len) begin
					play_done = 1'b1;
				end
			end
		end
	end

	initial begin
		int kind;
		void'($urandom(98));
		errors = 0;
		hangs = 0;
		reset125 = 1'b1;
		read = 1'b0;
		register_select = 1'b0;
		enable = 1'b0;
		bus_in = '0;
		play_arm = 1'b0;
		play_len = 0;
		model_mem = '{default: '0};
		ptr = '0;
		last_kind = 0;
		half = `HALVES_PER_WORD - 1;
		wbuf = '0;
		rbuf = '0;
		repeat (8) @(posedge clock);
		#2;
		reset125 = 1'b0;

		// idle outputs, then zero bytes from a cleared memory
		@(negedge clock);
		if (ack_valid !== 1'b0 || bus_oe !== 1'b0) begin
			errors++;
			$display("ERROR %0t ns: ack_valid or bus_oe high after reset", $time);
		end
		check_playback(256);

		// one word written and read back
		set_address(8'h10);
		write_half(16'hcafe);
		write_half(16'h1234);
		set_address(8'h10);
		read_half();
		read_half();

		// auto-increment over four words
		set_address(8'h40);
		repeat (8) write_half(half_t'($urandom));
		set_address(8'h40);
		repeat (8) read_half();

		// high half only, a taken pulse would complete the word
		set_address(8'h80);
		write_half(16'hbeef);

		// single cycle enable pulse must be ignored
		@(posedge clock);
		#2;
		read = 1'b0;
		register_select = 1'b1;
		bus_in = 16'hdead;
		enable = 1'b1;
		@(posedge clock);
		#2;
		enable = 1'b0;
		repeat (20) begin
			@(negedge clock);
			if (ack_valid) begin
				errors++;
				$display("ERROR %0t ns: ack_valid after a one-cycle enable pulse", $time);
			end
		end
		set_address(8'h80);
		read_half();
		read_half();

		// full loop against the model with the host idle
		repeat (8) @(posedge clock);
		check_playback(LOOP);

		// random mix over the whole address range
		repeat (40) begin
			kind = $urandom_range(K_READ, K_ADDR);
			if (kind == K_ADDR) begin
				set_address(addr_t'($urandom));
			end else if (kind == K_WRITE) begin
				write_half(half_t'($urandom));
			end else begin
				read_half();
			end
		end

		$display("summary: %0d check errors, %0d handshake timeouts", errors, hangs);
		if (errors == 0 && hangs == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== pollable_memory_top.sv ====
// ------------------------------
// pollable waveform memory top
// host bus engine and playback on one memory
// ------------------------------
`timescale 1ns/1ns

module pollable_memory_top (
	input logic clock,
	input logic reset125,
	input logic read, // 0 write, 1 read
	input logic register_select, // 0 address, 1 data
	input logic enable,
	input pollable_pkg::half_t bus_in,
	output pollable_pkg::half_t bus_out,
	output logic bus_oe,
	output logic ack_valid,
	output pollable_pkg::play_byte_t play_byte,
	output logic play_sync
);

	mem_port_if bus_port ();
	mem_port_if play_port ();

	bus_slave_engine u_bus_engine (
		.clock(clock),
		.reset125(reset125),
		.read(read),
		.register_select(register_select),
		.enable(enable),
		.bus_in(bus_in),
		.bus_out(bus_out),
		.bus_oe(bus_oe),
		.ack_valid(ack_valid),
		.mem(bus_port)
	);

	shared_waveform_memory u_memory (
		.clock(clock),
		.reset125(reset125),
		.bus_port(bus_port),
		.play_port(play_port)
	);

	playback_reader u_playback (
		.clock(clock),
		.reset125(reset125),
		.play_byte(play_byte),
		.play_sync(play_sync),
		.mem(play_port)
	);

endmodule

// ==== pollable_pkg.sv ====
// ------------------------------
// pollable memory types
// ------------------------------
`include "pollable_consts.svh"

package pollable_pkg;

	typedef logic [`BUS_WIDTH-1:0] half_t;
	typedef logic [`HALVES_PER_WORD*`BUS_WIDTH-1:0] word_t;
	typedef logic [`ADDR_BITS-1:0] addr_t;
	typedef logic [$bits(word_t)/`BYTES_PER_WORD-1:0] play_byte_t;

	// host control lines as one sample
	typedef struct packed {
		logic read; // 0 write, 1 read
		logic register_select; // 0 address, 1 data
		logic enable;
	} bus_ctrl_t;

	typedef enum logic [1:0] {
		PHASE_IDLE,
		PHASE_ADDRESS,
		PHASE_WRITE,
		PHASE_READ
	} phase_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the pollable memory simulation with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module pollable_memory_tb -o pollable_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/pollable_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sample_delay.sv ====
// ------------------------------
// sample delay chain
// shift register with every stage exposed
// ------------------------------
`timescale 1ns/1ns

module sample_delay #(
	parameter type T = logic,
	parameter int DEPTH = 2
) (
	input logic clock,
	input logic reset125,
	input T d,
	output T taps [DEPTH]
);

	always_ff @(posedge clock) begin
		if (reset125) begin
			for (int i = 0; i < DEPTH; i++) begin
				taps[i] <= '0;
			end
		end else begin
			taps[0] <= d; // newest sample
			for (int i = 1; i < DEPTH; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

endmodule

// ==== shared_waveform_memory.sv ====
// ------------------------------
// shared waveform memory
// single port array, playback has priority
// ------------------------------
`timescale 1ns/1ns
`include "pollable_consts.svh"

module shared_waveform_memory (
	input logic clock,
	input logic reset125,
	mem_port_if.memory bus_port,
	mem_port_if.memory play_port
);
	import pollable_pkg::*;

	localparam int WORDS = 1 << `ADDR_BITS;

	word_t mem_array [WORDS];
	word_t rdata_q;

	// fixed priority, bus only gets idle cycles
	assign play_port.grant = play_port.req;
	assign bus_port.grant = bus_port.req & ~play_port.req;

	assign play_port.rdata = rdata_q;
	assign bus_port.rdata = rdata_q;

	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem_array[i] = '0;
		end
	end

	// ------------------------------
	// one access per cycle
	// ------------------------------
	always_ff @(posedge clock) begin
		if (play_port.grant) begin
			if (play_port.we) begin
				mem_array[play_port.addr] <= play_port.wdata;
			end
			rdata_q <= mem_array[play_port.addr];
		end else if (bus_port.grant) begin
			if (bus_port.we) begin
				mem_array[bus_port.addr] <= bus_port.wdata;
			end
			rdata_q <= mem_array[bus_port.addr];
		end
	end

	always_ff @(posedge clock) begin
		if (reset125) begin
			play_port.rvalid <= 1'b0;
			bus_port.rvalid <= 1'b0;
		end else begin
			play_port.rvalid <= play_port.grant & ~play_port.we;
			bus_port.rvalid <= bus_port.grant & ~bus_port.we;
		end
	end

endmodule
